// ==== verilog/adc_regmap_pkg.sv ====
`default_nettype none

package adc_regmap_pkg;

	localparam int UP_ADDR_W = 14; // Word address taken from byte address bits 15 to 2.

	typedef struct packed {
		logic req;
		logic [UP_ADDR_W-1:0] addr;
		logic [31:0] data;
	} up_wreq_t;

	typedef struct packed {
		logic req;
		logic [UP_ADDR_W-1:0] addr;
	} up_rreq_t;

	typedef struct packed {
		logic wack;
		logic rack;
		logic [31:0] rdata; // Zero unless rack is set.
	} up_rsp_t;

	localparam logic [UP_ADDR_W-1:0] REG_VERSION = 14'h000;
	localparam logic [UP_ADDR_W-1:0] REG_ID = 14'h001;
	localparam logic [UP_ADDR_W-1:0] REG_SCRATCH = 14'h002;
	localparam logic [UP_ADDR_W-1:0] REG_RSTN = 14'h010;
	localparam logic [UP_ADDR_W-1:0] REG_STATUS = 14'h017;

	localparam logic [31:0] CORE_VERSION = 32'h00090062;

	localparam logic [UP_ADDR_W-1:0] CHAN_BASE = 14'h100;
	localparam logic [UP_ADDR_W-1:0] CHAN_STRIDE = 14'h010;

	localparam int CHAN_ENABLE_BIT = 0;
	localparam int CHAN_FMT_SIGNED_BIT = 2;
	localparam int CHAN_FMT_ENABLE_BIT = 6;
	localparam logic [31:0] CHAN_CNTRL_MASK = (32'd1 << CHAN_ENABLE_BIT) |
		(32'd1 << CHAN_FMT_SIGNED_BIT) | (32'd1 << CHAN_FMT_ENABLE_BIT);

	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
	localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

	localparam int UP_TIMEOUT = 31; // Cycles without ack before SLVERR.

endpackage

`default_nettype wire

// ==== verilog/up_axi_bridge.sv ====
`default_nettype none

module up_axi_bridge (
	input wire logic up_clk,
	input wire logic up_rstn,

	input wire logic s_axi_awvalid,
	input wire logic [31:0] s_axi_awaddr,
	output logic s_axi_awready,
	input wire logic s_axi_wvalid,
	input wire logic [31:0] s_axi_wdata,
	input wire logic [3:0] s_axi_wstrb,
	output logic s_axi_wready,
	output logic s_axi_bvalid,
	output logic [1:0] s_axi_bresp,
	input wire logic s_axi_bready,
	input wire logic s_axi_arvalid,
	input wire logic [31:0] s_axi_araddr,
	output logic s_axi_arready,
	output logic s_axi_rvalid,
	output logic [1:0] s_axi_rresp,
	output logic [31:0] s_axi_rdata,
	input wire logic s_axi_rready,

	output adc_regmap_pkg::up_wreq_t wreq,
	output adc_regmap_pkg::up_rreq_t rreq,
	input wire adc_regmap_pkg::up_rsp_t rsp
);

localparam int AW = adc_regmap_pkg::UP_ADDR_W;
localparam int TMR_W = $clog2(adc_regmap_pkg::UP_TIMEOUT + 1);

localparam logic [1:0] ST_IDLE = 2'd0;
localparam logic [1:0] ST_REQ = 2'd1;
localparam logic [1:0] ST_WAIT = 2'd2;
localparam logic [1:0] ST_RESP = 2'd3;

logic [1:0] state;
logic op_wr; // Transaction in flight is a write.
logic last_wr; // Last grant went to the write side.
logic [TMR_W-1:0] timer;
logic wreq_req;
logic rreq_req;
logic bvalid;
logic rvalid;
logic [1:0] resp;
logic [AW-1:0] addr_q;
logic [31:0] wdata_q;
logic [31:0] rdata_q;

logic wr_pend;
logic rd_pend;
logic grant_wr;
logic grant_rd;
logic ack;
logic timed_out;
logic done;

assign wr_pend = s_axi_awvalid & s_axi_wvalid;
assign rd_pend = s_axi_arvalid;

// Round robin between the two sides when both are pending.
assign grant_wr = (state == ST_IDLE) & wr_pend & (~rd_pend | ~last_wr);
assign grant_rd = (state == ST_IDLE) & rd_pend & ~grant_wr;

assign ack = op_wr ? rsp.wack : rsp.rack;
assign timed_out = (timer == TMR_W'(adc_regmap_pkg::UP_TIMEOUT - 1));
assign done = (state == ST_WAIT) & (ack | timed_out);

always_ff @(posedge up_clk) begin
	if (!up_rstn) begin
		state <= ST_IDLE;
		op_wr <= 1'b0;
		last_wr <= 1'b0;
		timer <= '0;
		wreq_req <= 1'b0;
		rreq_req <= 1'b0;
		bvalid <= 1'b0;
		rvalid <= 1'b0;
		resp <= adc_regmap_pkg::AXI_RESP_OKAY;
	end else begin
		wreq_req <= 1'b0; // Requests are single-cycle pulses.
		rreq_req <= 1'b0;
		case (state)
			ST_IDLE: begin
				if (grant_wr || grant_rd) begin
					op_wr <= grant_wr;
					last_wr <= grant_wr;
					state <= ST_REQ;
				end
			end
			ST_REQ: begin
				wreq_req <= op_wr;
				rreq_req <= ~op_wr;
				timer <= '0;
				state <= ST_WAIT;
			end
			ST_WAIT: begin
				timer <= timer + 1'b1;
				if (done) begin
					resp <= ack ? adc_regmap_pkg::AXI_RESP_OKAY :
						adc_regmap_pkg::AXI_RESP_SLVERR;
					bvalid <= op_wr;
					rvalid <= ~op_wr;
					state <= ST_RESP;
				end
			end
			default: begin
				if ((bvalid && s_axi_bready) || (rvalid && s_axi_rready)) begin
					bvalid <= 1'b0;
					rvalid <= 1'b0;
					state <= ST_IDLE;
				end
			end
		endcase
	end
end

// Address and write data are taken on a grant and read data on completion.
always_ff @(posedge up_clk) begin
	if (grant_wr) begin
		addr_q <= s_axi_awaddr[15:2];
		wdata_q <= s_axi_wdata;
	end else if (grant_rd) begin
		addr_q <= s_axi_araddr[15:2];
	end
	if (done && !op_wr) begin
		rdata_q <= ack ? rsp.rdata : 32'd0;
	end
end

assign wreq.req = wreq_req;
assign wreq.addr = addr_q;
assign wreq.data = wdata_q;
assign rreq.req = rreq_req;
assign rreq.addr = addr_q;

assign s_axi_awready = grant_wr;
assign s_axi_wready = grant_wr;
assign s_axi_arready = grant_rd;
assign s_axi_bvalid = bvalid;
assign s_axi_bresp = resp;
assign s_axi_rvalid = rvalid;
assign s_axi_rresp = resp;
assign s_axi_rdata = rdata_q;

endmodule

`default_nettype wire

// ==== verilog/up_adc_common.sv ====
`default_nettype none

module up_adc_common #(
	parameter logic [31:0] PCORE_ID = 32'd0
) (
	input wire logic up_clk,
	input wire logic up_rstn,
	input wire adc_regmap_pkg::up_wreq_t wreq,
	input wire adc_regmap_pkg::up_rreq_t rreq,
	output adc_regmap_pkg::up_rsp_t rsp,

	input wire logic adc_clk,
	output logic adc_rst,
	input wire logic adc_dovf
);

localparam int AW = adc_regmap_pkg::UP_ADDR_W;

logic [31:0] up_scratch;
logic up_adc_resetn; // The converter is held in reset while this REG_RSTN bit is low.
logic [1:0] up_dovf_m;
logic up_status_ovf;
logic [1:0] adc_rst_m;

logic wr_hit;
logic rd_hit;
logic ovf_clr;
logic [31:0] rd_data;

function automatic logic is_common(input logic [AW-1:0] addr);
	case (addr)
		adc_regmap_pkg::REG_VERSION,
		adc_regmap_pkg::REG_ID,
		adc_regmap_pkg::REG_SCRATCH,
		adc_regmap_pkg::REG_RSTN,
		adc_regmap_pkg::REG_STATUS: is_common = 1'b1;
		default: is_common = 1'b0;
	endcase
endfunction

assign wr_hit = wreq.req & is_common(wreq.addr);
assign rd_hit = rreq.req & is_common(rreq.addr);
assign ovf_clr = wr_hit && (wreq.addr == adc_regmap_pkg::REG_STATUS) && wreq.data[0];

always_comb begin
	case (rreq.addr)
		adc_regmap_pkg::REG_VERSION: rd_data = adc_regmap_pkg::CORE_VERSION;
		adc_regmap_pkg::REG_ID: rd_data = PCORE_ID;
		adc_regmap_pkg::REG_SCRATCH: rd_data = up_scratch;
		adc_regmap_pkg::REG_RSTN: rd_data = {31'd0, up_adc_resetn};
		adc_regmap_pkg::REG_STATUS: rd_data = {31'd0, up_status_ovf};
		default: rd_data = 32'd0;
	endcase
end

always_ff @(posedge up_clk) begin
	if (!up_rstn) begin
		up_scratch <= 32'd0;
		up_adc_resetn <= 1'b0;
		up_dovf_m <= 2'd0;
		up_status_ovf <= 1'b0;
		rsp <= '0;
	end else begin
		up_dovf_m <= {up_dovf_m[0], adc_dovf};
		if (wr_hit && (wreq.addr == adc_regmap_pkg::REG_SCRATCH)) begin
			up_scratch <= wreq.data;
		end
		if (wr_hit && (wreq.addr == adc_regmap_pkg::REG_RSTN)) begin
			up_adc_resetn <= wreq.data[0];
		end
		up_status_ovf <= up_dovf_m[1] | (up_status_ovf & ~ovf_clr); // Set wins over clear.
		rsp.wack <= wr_hit;
		rsp.rack <= rd_hit;
		rsp.rdata <= rd_hit ? rd_data : 32'd0;
	end
end

// The converter reset follows the register bit through two adc_clk flops.
always_ff @(posedge adc_clk) begin
	adc_rst_m <= {adc_rst_m[0], ~up_adc_resetn};
end

assign adc_rst = adc_rst_m[1];

endmodule

`default_nettype wire

// ==== verilog/up_adc_channel.sv ====
`default_nettype none

module up_adc_channel #(
	parameter int CHID = 0
) (
	input wire logic up_clk,
	input wire logic up_rstn,
	input wire adc_regmap_pkg::up_wreq_t wreq,
	input wire adc_regmap_pkg::up_rreq_t rreq,
	output adc_regmap_pkg::up_rsp_t rsp,

	input wire logic adc_clk,
	input wire logic adc_rst,
	output logic adc_enable
);

localparam int AW = adc_regmap_pkg::UP_ADDR_W;
localparam logic [AW-1:0] CNTRL_ADDR =
	AW'(adc_regmap_pkg::CHAN_BASE + CHID * adc_regmap_pkg::CHAN_STRIDE);

logic [31:0] up_cntrl; // Only the masked bits are ever set.
logic [1:0] adc_enable_m;

logic wr_hit;
logic rd_hit;

assign wr_hit = wreq.req && (wreq.addr == CNTRL_ADDR);
assign rd_hit = rreq.req && (rreq.addr == CNTRL_ADDR);

always_ff @(posedge up_clk) begin
	if (!up_rstn) begin
		up_cntrl <= 32'd0;
		rsp <= '0;
	end else begin
		if (wr_hit) begin
			up_cntrl <= wreq.data & adc_regmap_pkg::CHAN_CNTRL_MASK;
		end
		rsp.wack <= wr_hit;
		rsp.rack <= rd_hit;
		rsp.rdata <= rd_hit ? up_cntrl : 32'd0;
	end
end

// Enable crosses into adc_clk and is held off while the converter is in reset.
always_ff @(posedge adc_clk) begin
	if (adc_rst) begin
		adc_enable_m <= 2'd0;
	end else begin
		adc_enable_m <= {adc_enable_m[0], up_cntrl[adc_regmap_pkg::CHAN_ENABLE_BIT]};
	end
end

assign adc_enable = adc_enable_m[1];

endmodule

`default_nettype wire

// ==== verilog/axi_generic_adc.sv ====
`default_nettype none

module axi_generic_adc #(
	parameter int NUM_CHANNELS = 2,
	parameter logic [31:0] PCORE_ID = 32'd0
) (
	input wire adc_clk,
	output wire [NUM_CHANNELS-1:0] adc_enable,
	input wire adc_dovf,

	input wire s_axi_aclk,
	input wire s_axi_aresetn,
	input wire s_axi_awvalid,
	input wire [31:0] s_axi_awaddr,
	output wire s_axi_awready,
	input wire s_axi_wvalid,
	input wire [31:0] s_axi_wdata,
	input wire [3:0] s_axi_wstrb,
	output wire s_axi_wready,
	output wire s_axi_bvalid,
	output wire [1:0] s_axi_bresp,
	input wire s_axi_bready,
	input wire s_axi_arvalid,
	input wire [31:0] s_axi_araddr,
	output wire s_axi_arready,
	output wire s_axi_rvalid,
	output wire [1:0] s_axi_rresp,
	output wire [31:0] s_axi_rdata,
	input wire s_axi_rready
);

wire up_clk;
wire up_rstn;
wire adc_rst;

adc_regmap_pkg::up_wreq_t wreq;
adc_regmap_pkg::up_rreq_t rreq;
adc_regmap_pkg::up_rsp_t peer_rsp [0:NUM_CHANNELS]; // Common block sits at the top index.
adc_regmap_pkg::up_rsp_t rsp_or;
adc_regmap_pkg::up_rsp_t rsp_q;

assign up_clk = s_axi_aclk;
assign up_rstn = s_axi_aresetn;

// Peers drive zeros when not addressed, so a plain OR merges them.
always_comb begin
	rsp_or = '0;
	for (int j = 0; j <= NUM_CHANNELS; j++) begin
		rsp_or = rsp_or | peer_rsp[j];
	end
end

always_ff @(posedge up_clk) begin
	if (!up_rstn) begin
		rsp_q <= '0;
	end else begin
		rsp_q <= rsp_or;
	end
end

up_axi_bridge i_up_axi_bridge (
	.up_clk (up_clk),
	.up_rstn (up_rstn),
	.s_axi_awvalid (s_axi_awvalid),
	.s_axi_awaddr (s_axi_awaddr),
	.s_axi_awready (s_axi_awready),
	.s_axi_wvalid (s_axi_wvalid),
	.s_axi_wdata (s_axi_wdata),
	.s_axi_wstrb (s_axi_wstrb),
	.s_axi_wready (s_axi_wready),
	.s_axi_bvalid (s_axi_bvalid),
	.s_axi_bresp (s_axi_bresp),
	.s_axi_bready (s_axi_bready),
	.s_axi_arvalid (s_axi_arvalid),
	.s_axi_araddr (s_axi_araddr),
	.s_axi_arready (s_axi_arready),
	.s_axi_rvalid (s_axi_rvalid),
	.s_axi_rresp (s_axi_rresp),
	.s_axi_rdata (s_axi_rdata),
	.s_axi_rready (s_axi_rready),
	.wreq (wreq),
	.rreq (rreq),
	.rsp (rsp_q));

up_adc_common #(.PCORE_ID(PCORE_ID)) i_up_adc_common (
	.up_clk (up_clk),
	.up_rstn (up_rstn),
	.wreq (wreq),
	.rreq (rreq),
	.rsp (peer_rsp[NUM_CHANNELS]),
	.adc_clk (adc_clk),
	.adc_rst (adc_rst),
	.adc_dovf (adc_dovf));

generate
	for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_channel
		up_adc_channel #(.CHID(i)) i_up_adc_channel (
			.up_clk (up_clk),
			.up_rstn (up_rstn),
			.wreq (wreq),
			.rreq (rreq),
			.rsp (peer_rsp[i]),
			.adc_clk (adc_clk),
			.adc_rst (adc_rst),
			.adc_enable (adc_enable[i]));
	end
endgenerate

endmodule

`default_nettype wire

// ==== verification/axi_lite_master.svh ====
`ifndef AXI_LITE_MASTER_SVH
`define AXI_LITE_MASTER_SVH

function automatic logic [31:0] byte_addr(input logic [13:0] word);
	byte_addr = {16'd0, word, 2'b00}; // Internal bus uses byte address bits 15 to 2.
endfunction

task automatic reg_write(input logic [13:0] addr, input logic [31:0] data,
	output logic [1:0] resp);
	@(negedge s_axi_aclk);
	s_axi_awvalid = 1'b1;
	s_axi_awaddr = byte_addr(addr);
	s_axi_wvalid = 1'b1;
	s_axi_wdata = data;
	s_axi_wstrb = 4'hf;
	s_axi_bready = 1'b1;
	do begin
		@(posedge s_axi_aclk);
	end while (!s_axi_awready); // Address and data are taken at this edge.
	@(negedge s_axi_aclk);
	s_axi_awvalid = 1'b0;
	s_axi_wvalid = 1'b0;
	do begin
		@(posedge s_axi_aclk);
	end while (!s_axi_bvalid);
	resp = s_axi_bresp;
	@(negedge s_axi_aclk);
	s_axi_bready = 1'b0;
endtask

task automatic reg_read(input logic [13:0] addr, output logic [31:0] data,
	output logic [1:0] resp);
	@(negedge s_axi_aclk);
	s_axi_arvalid = 1'b1;
	s_axi_araddr = byte_addr(addr);
	s_axi_rready = 1'b1;
	do begin
		@(posedge s_axi_aclk);
	end while (!s_axi_arready);
	@(negedge s_axi_aclk);
	s_axi_arvalid = 1'b0;
	do begin
		@(posedge s_axi_aclk);
	end while (!s_axi_rvalid);
	data = s_axi_rdata;
	resp = s_axi_rresp;
	@(negedge s_axi_aclk);
	s_axi_rready = 1'b0;
endtask

`endif

// ==== verification/axi_generic_adc_tb.sv ====
`default_nettype none

module axi_generic_adc_tb;

localparam logic [13:0] REG_ID = 14'h001;
localparam logic [13:0] REG_VERSION = 14'h000;
localparam logic [13:0] REG_SCRATCH = 14'h002;
localparam logic [13:0] REG_RSTN = 14'h010;
localparam logic [13:0] REG_STATUS = 14'h017;
localparam logic [13:0] UNMAPPED = 14'h3000;
localparam logic [31:0] EXP_VERSION = 32'h0009_0062;
localparam logic [31:0] CNTRL_MASK = 32'h0000_0045; // Bits 6, 2 and 0.
localparam logic [1:0] OKAY = 2'b00;
localparam logic [1:0] SLVERR = 2'b10;
localparam int TEST_CYCLES = 40;
localparam int NUM_TESTS = 6;
localparam int MAX_CYCLES = NUM_TESTS * TEST_CYCLES * 8 + 80; // Gives 2000 cycles with a wide margin.

logic s_axi_aclk, s_axi_aresetn, adc_clk, adc_dovf;
logic s_axi_awvalid, s_axi_wvalid, s_axi_bready, s_axi_arvalid, s_axi_rready;
logic s_axi_awready, s_axi_wready, s_axi_bvalid, s_axi_arready, s_axi_rvalid;
logic [31:0] s_axi_awaddr, s_axi_wdata, s_axi_araddr, s_axi_rdata;
logic [3:0] s_axi_wstrb;
logic [1:0] s_axi_bresp, s_axi_rresp;
logic [1:0] adc_enable;

integer seed;
int errors;
int checks;
int test_errors;
int cycles;

axi_generic_adc #(.NUM_CHANNELS(2), .PCORE_ID(32'd5)) axi_generic_adc_inst (
	.adc_clk (adc_clk),
	.adc_enable (adc_enable),
	.adc_dovf (adc_dovf),
	.s_axi_aclk (s_axi_aclk),
	.s_axi_aresetn (s_axi_aresetn),
	.s_axi_awvalid (s_axi_awvalid),
	.s_axi_awaddr (s_axi_awaddr),
	.s_axi_awready (s_axi_awready),
	.s_axi_wvalid (s_axi_wvalid),
	.s_axi_wdata (s_axi_wdata),
	.s_axi_wstrb (s_axi_wstrb),
	.s_axi_wready (s_axi_wready),
	.s_axi_bvalid (s_axi_bvalid),
	.s_axi_bresp (s_axi_bresp),
	.s_axi_bready (s_axi_bready),
	.s_axi_arvalid (s_axi_arvalid),
	.s_axi_araddr (s_axi_araddr),
	.s_axi_arready (s_axi_arready),
	.s_axi_rvalid (s_axi_rvalid),
	.s_axi_rresp (s_axi_rresp),
	.s_axi_rdata (s_axi_rdata),
	.s_axi_rready (s_axi_rready));

`include "axi_lite_master.svh"

initial begin
	s_axi_aclk = 1'b0;
	forever #2 s_axi_aclk = ~s_axi_aclk;
end

initial begin
	adc_clk = 1'b0;
	forever #3 adc_clk = ~adc_clk;
end

always @(posedge s_axi_aclk) begin
	cycles++;
	if (cycles >= MAX_CYCLES) begin
		$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
		$display("Result: FAILED");
		$finish;
	end
end

// The write address and write data channels are accepted in the same cycle.
always @(posedge s_axi_aclk) begin
	assert (s_axi_wready === s_axi_awready) else begin
		$display("** Error at %0t: s_axi_wready is %b, expected %b", $time,
			s_axi_wready, s_axi_awready);
		errors++;
	end
end

function automatic logic [13:0] chan_addr(input int i);
	chan_addr = 14'h100 + 14'(i) * 14'h010;
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	assert (got === exp) else begin
		$display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		errors++;
	end
endtask

task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
	checks++;
	assert (got === exp) else begin
		$display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
		errors++;
	end
endtask

task automatic read_check(input logic [13:0] addr, input logic [31:0] exp, input string name);
	logic [31:0] data;
	logic [1:0] resp;
	reg_read(addr, data, resp);
	check_value(name, data, exp);
	check_resp({name, " rresp"}, resp, OKAY);
endtask

task automatic write_ok(input logic [13:0] addr, input logic [31:0] data, input string name);
	logic [1:0] resp;
	reg_write(addr, data, resp);
	check_resp({name, " bresp"}, resp, OKAY);
endtask

task automatic wait_enable(input logic [1:0] exp);
	int n;
	n = 0;
	while (adc_enable !== exp && n < 10) begin
		@(negedge adc_clk);
		n++;
	end
	checks++;
	assert (adc_enable === exp) else begin
		$display("** Error at %0t: adc_enable is %b, expected %b within 10 adc_clk cycles",
			$time, adc_enable, exp);
		errors++;
	end
endtask

task automatic end_test(input int num, input string name);
	$display("Test %0d %s finished with %0d errors", num, name, errors - test_errors);
	test_errors = errors;
endtask

initial begin
	logic [31:0] rdata;
	logic [31:0] wdata;
	logic [1:0] resp;
	logic [1:0] resp2;
	seed = 32'h5d6512d2;
	errors = 0;
	checks = 0;
	test_errors = 0;
	cycles = 0;
	s_axi_aresetn = 1'b0;
	adc_dovf = 1'b0;
	s_axi_awvalid = 1'b0;
	s_axi_awaddr = 32'd0;
	s_axi_wvalid = 1'b0;
	s_axi_wdata = 32'd0;
	s_axi_wstrb = 4'h0;
	s_axi_bready = 1'b0;
	s_axi_arvalid = 1'b0;
	s_axi_araddr = 32'd0;
	s_axi_rready = 1'b0;
	repeat (8) @(posedge s_axi_aclk);
	@(negedge s_axi_aclk);
	s_axi_aresetn = 1'b1;

	check_value("ready and valid outputs", {27'd0, s_axi_awready, s_axi_wready,
		s_axi_bvalid, s_axi_arready, s_axi_rvalid}, 32'd0);
	read_check(REG_VERSION, EXP_VERSION, "REG_VERSION");
	read_check(REG_ID, 32'd5, "REG_ID");
	read_check(REG_SCRATCH, 32'd0, "REG_SCRATCH");
	read_check(REG_RSTN, 32'd0, "REG_RSTN");
	read_check(REG_STATUS, 32'd0, "REG_STATUS");
	for (int i = 0; i < 2; i++) begin
		read_check(chan_addr(i), 32'd0, "channel control");
	end
	check_value("adc_enable", {30'd0, adc_enable}, 32'd0);
	end_test(1, "reset state and identity");

	for (int k = 0; k < 3; k++) begin
		wdata = $random(seed);
		write_ok(REG_SCRATCH, wdata, "REG_SCRATCH");
		read_check(REG_SCRATCH, wdata, "REG_SCRATCH");
	end
	for (int i = 0; i < 2; i++) begin
		wdata = $random(seed);
		write_ok(chan_addr(i), wdata, "channel control");
		read_check(chan_addr(i), wdata & CNTRL_MASK, "channel control");
	end
	end_test(2, "scratch and control readback");

	write_ok(chan_addr(0), 32'd0, "channel 0 control");
	write_ok(chan_addr(1), 32'd1, "channel 1 control");
	write_ok(REG_RSTN, 32'd1, "REG_RSTN");
	wait_enable(2'b10);
	write_ok(REG_RSTN, 32'd0, "REG_RSTN");
	wait_enable(2'b00);
	end_test(3, "channel enable path");

	@(negedge adc_clk);
	adc_dovf = 1'b1;
	@(negedge adc_clk);
	adc_dovf = 1'b0;
	repeat (4) @(negedge s_axi_aclk); // Let the pulse pass the synchronizer.
	read_check(REG_STATUS, 32'd1, "REG_STATUS");
	read_check(REG_STATUS, 32'd1, "REG_STATUS");
	write_ok(REG_STATUS, 32'd1, "REG_STATUS");
	read_check(REG_STATUS, 32'd0, "REG_STATUS");
	end_test(4, "overflow flag");

	reg_read(UNMAPPED, rdata, resp);
	check_resp("unmapped rresp", resp, SLVERR);
	check_value("unmapped rdata", rdata, 32'd0);
	wdata = $random(seed);
	reg_write(UNMAPPED, wdata, resp);
	check_resp("unmapped bresp", resp, SLVERR);
	read_check(REG_ID, 32'd5, "REG_ID");
	end_test(5, "unmapped address");

	// The last grant was a read, so the write side wins the first grant.
	wdata = $random(seed);
	fork
		reg_write(REG_SCRATCH, wdata, resp);
		reg_read(REG_ID, rdata, resp2);
		begin
			do begin
				@(posedge s_axi_aclk);
			end while (!s_axi_awready && !s_axi_arready);
			check_value("first grant {awready, arready}",
				{30'd0, s_axi_awready, s_axi_arready}, 32'd2);
		end
	join
	check_resp("bresp", resp, OKAY);
	check_resp("rresp", resp2, OKAY);
	check_value("REG_ID", rdata, 32'd5);
	read_check(REG_SCRATCH, wdata, "REG_SCRATCH");
	end_test(6, "arbitration");

	$display("Tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, checks, errors);
	if (errors == 0) begin
		$display("Result: PASSED");
	end else begin
		$display("Result: FAILED");
	end
	$finish;
end

endmodule

`default_nettype wire

// ==== axi_generic_adc.f ====
+incdir+verification
verilog/adc_regmap_pkg.sv
verilog/up_axi_bridge.sv
verilog/up_adc_common.sv
verilog/up_adc_channel.sv
verilog/axi_generic_adc.sv
verification/axi_generic_adc_tb.sv

// ==== Makefile ====
# Verilator build and run for axi_generic_adc.

VERILATOR ?= verilator
TOP ?= axi_generic_adc_tb
RTL_TOP ?= axi_generic_adc
FILELIST ?= axi_generic_adc.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Result: PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
